/* rtl/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      alu_op_t;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 for alu ops
  localparam logic [2:0] f3_add  = 3'b000; // add, sub
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101; // srl, sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 for branches and word access
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;
  localparam logic [2:0] f3_word = 3'b010; // lw / sw

  localparam logic [6:0] funct7_alt = 7'b0100000; // sub, sra

  localparam alu_op_t alu_add    = 4'd0;
  localparam alu_op_t alu_sub    = 4'd1;
  localparam alu_op_t alu_sll    = 4'd2;
  localparam alu_op_t alu_slt    = 4'd3;
  localparam alu_op_t alu_sltu   = 4'd4;
  localparam alu_op_t alu_xor    = 4'd5;
  localparam alu_op_t alu_srl    = 4'd6;
  localparam alu_op_t alu_sra    = 4'd7;
  localparam alu_op_t alu_or     = 4'd8;
  localparam alu_op_t alu_and    = 4'd9;
  localparam alu_op_t alu_pass_b = 4'd10;

  // register write source
  localparam logic [1:0] wb_alu  = 2'd0;
  localparam logic [1:0] wb_load = 2'd1;
  localparam logic [1:0] wb_pc4  = 2'd2;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, seen through each format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_t;

endpackage

/* rtl/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  input  logic            use_imm,
  input  rv_pkg::alu_op_t alu_op,
  input  logic [2:0]      funct3,
  output rv_pkg::word_t   result,
  output logic            branch_cond
);

  rv_pkg::word_t b;
  logic [4:0]    shamt;
  logic          lt_s;
  logic          lt_u;

  assign b     = use_imm ? imm : rs2_data;
  assign shamt = b[4:0]; // srai keeps its alt bit above this

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:    result = a + b;
      rv_pkg::alu_sub:    result = a - b;
      rv_pkg::alu_sll:    result = a << shamt;
      rv_pkg::alu_slt:    result = {31'd0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu:   result = {31'd0, a < b};
      rv_pkg::alu_xor:    result = a ^ b;
      rv_pkg::alu_srl:    result = a >> shamt;
      rv_pkg::alu_sra:    result = $signed(a) >>> shamt;
      rv_pkg::alu_or:     result = a | b;
      rv_pkg::alu_and:    result = a & b;
      rv_pkg::alu_pass_b: result = b; // lui
      default:            result = '0;
    endcase
  end

  // branches always compare the two registers
  assign lt_s = $signed(a) < $signed(rs2_data);
  assign lt_u = a < rs2_data;

  always_comb begin
    case (funct3)
      rv_pkg::f3_beq:  branch_cond = (a == rs2_data);
      rv_pkg::f3_bne:  branch_cond = (a != rs2_data);
      rv_pkg::f3_blt:  branch_cond = lt_s;
      rv_pkg::f3_bge:  branch_cond = ~lt_s;
      rv_pkg::f3_bltu: branch_cond = lt_u;
      rv_pkg::f3_bgeu: branch_cond = ~lt_u;
      default:         branch_cond = 1'b0;
    endcase
  end

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile #(
  parameter int num_regs = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rd,
  input  logic             we,
  input  logic [1:0]       wb_sel,
  input  rv_pkg::word_t    alu_result,
  input  rv_pkg::word_t    load_data,
  input  rv_pkg::word_t    pc_plus4
);

  rv_pkg::word_t regs [1:num_regs-1]; // x0 has no storage
  rv_pkg::word_t wdata;

  always_comb begin
    case (wb_sel)
      rv_pkg::wb_load: wdata = load_data;
      rv_pkg::wb_pc4:  wdata = pc_plus4; // jal link
      default:         wdata = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) regs[i] <= '0;
    end else if (we && (rd != 5'd0) && (rd < num_regs)) begin
      regs[rd] <= wdata;
    end
  end

  // x0 and indices past num_regs read as zero
  assign rs1_data = ((rs1 == 5'd0) || (rs1 >= num_regs)) ? '0 : regs[rs1];
  assign rs2_data = ((rs2 == 5'd0) || (rs2 >= num_regs)) ? '0 : regs[rs2];

endmodule

/* rtl/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode (
  input  rv_pkg::insn_t    insn,
  input  logic             halt,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm,
  output rv_pkg::word_t    offset,
  output rv_pkg::alu_op_t  alu_op,
  output logic             use_imm,
  output logic             branch,
  output logic [2:0]       funct3,
  output logic             jump,
  output logic             rf_we,
  output logic [1:0]       wb_sel,
  output logic             dmem_we,
  output logic             halt_req
);

  logic [6:0]    opcode;
  logic [6:0]    funct7;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;
  logic          wr_req;
  logic          st_req;
  logic          alt_ok;

  // bit 5 of funct7 picks sub or sra for op and op_imm
  function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      rv_pkg::f3_add:  alu_sel = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:  alu_sel = rv_pkg::alu_sll;
      rv_pkg::f3_slt:  alu_sel = rv_pkg::alu_slt;
      rv_pkg::f3_sltu: alu_sel = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:  alu_sel = rv_pkg::alu_xor;
      rv_pkg::f3_srl:  alu_sel = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:   alu_sel = rv_pkg::alu_or;
      default:         alu_sel = rv_pkg::alu_and;
    endcase
  endfunction

  // register fields sit at the same bits in every format
  assign opcode = insn.r_fmt.opcode;
  assign funct7 = insn.r_fmt.funct7;
  assign funct3 = insn.r_fmt.funct3;
  assign rs1    = insn.r_fmt.rs1;
  assign rs2    = insn.r_fmt.rs2;
  assign rd     = insn.r_fmt.rd;

  assign imm_i = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
  assign imm_s = {{20{insn.s_fmt.imm_hi[6]}}, insn.s_fmt.imm_hi, insn.s_fmt.imm_lo};
  assign imm_b = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                  insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {insn.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
                  insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};

  assign offset = (opcode == rv_pkg::op_jal) ? imm_j : imm_b;

  always_comb begin
    case (opcode)
      rv_pkg::op_lui:   imm = imm_u;
      rv_pkg::op_store: imm = imm_s;
      default:          imm = imm_i;
    endcase
  end

  // funct7 may only be alt on add/sub and the right shifts
  assign alt_ok = (funct7 == rv_pkg::funct7_alt) &&
                  ((funct3 == rv_pkg::f3_add) || (funct3 == rv_pkg::f3_srl));

  always_comb begin
    alu_op   = rv_pkg::alu_add;
    use_imm  = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    wr_req   = 1'b0;
    wb_sel   = rv_pkg::wb_alu;
    st_req   = 1'b0;
    halt_req = 1'b0;
    case (opcode)
      rv_pkg::op_lui: begin
        alu_op  = rv_pkg::alu_pass_b;
        use_imm = 1'b1;
        wr_req  = 1'b1;
      end
      rv_pkg::op_op_imm: begin
        use_imm = 1'b1;
        if (funct3 == rv_pkg::f3_sll) begin
          alu_op = rv_pkg::alu_sll;
          wr_req = (funct7 == 7'd0);
        end else if (funct3 == rv_pkg::f3_srl) begin
          alu_op = alu_sel(funct3, funct7[5]);
          wr_req = (funct7 == 7'd0) || (funct7 == rv_pkg::funct7_alt);
        end else begin
          alu_op = alu_sel(funct3, 1'b0); // no subi
          wr_req = 1'b1;
        end
      end
      rv_pkg::op_op: begin
        alu_op = alu_sel(funct3, funct7[5]);
        wr_req = (funct7 == 7'd0) || alt_ok; // mul/div encodings fall out here
      end
      rv_pkg::op_branch: begin
        branch = 1'b1; // funct3 010 and 011 never meet branch_cond
      end
      rv_pkg::op_jal: begin
        jump   = 1'b1;
        wr_req = 1'b1;
        wb_sel = rv_pkg::wb_pc4;
      end
      rv_pkg::op_load: begin
        use_imm = 1'b1;
        wr_req  = (funct3 == rv_pkg::f3_word);
        wb_sel  = rv_pkg::wb_load;
      end
      rv_pkg::op_store: begin
        use_imm = 1'b1;
        st_req  = (funct3 == rv_pkg::f3_word);
      end
      rv_pkg::op_system: begin
        halt_req = (insn.i_fmt.imm == 12'd0) && (rs1 == 5'd0) &&
                   (funct3 == 3'd0) && (rd == 5'd0); // ecall only
      end
      default: ; // unknown encodings just step past
    endcase
  end

  assign rf_we   = wr_req & ~halt;
  assign dmem_we = st_req & ~halt;

endmodule

/* rtl/rv_pc.sv */
`timescale 1ns/100ps

module rv_pc #(
  parameter rv_pkg::word_t reset_addr = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          halt_req,
  input  logic          branch_taken,
  input  logic          jump,
  input  rv_pkg::word_t offset,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4,
  output logic          halt
);

  rv_pkg::word_t target;
  rv_pkg::word_t pc_next;

  assign pc_plus4 = pc + 32'd4;
  assign target   = pc + offset; // b or j immediate

  always_comb begin
    if (halt) begin
      pc_next = pc; // frozen until rst
    end else if (branch_taken || jump) begin
      pc_next = target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_addr;
      halt <= 1'b0;
    end else begin
      pc <= pc_next;
      if (halt_req) halt <= 1'b1; // sticky
    end
  end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
  parameter rv_pkg::word_t reset_addr = '0,
  parameter int            num_regs   = 32
) (
  input  logic          clk,
  input  logic          rst,
  output logic          halt,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_we,
  input  rv_pkg::word_t dmem_rdata
);

  rv_pkg::word_t    pc;
  rv_pkg::word_t    pc_plus4;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    imm;
  rv_pkg::word_t    offset;
  rv_pkg::alu_op_t  alu_op;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_result;
  logic             use_imm;
  logic             branch;
  logic             branch_cond;
  logic             branch_taken;
  logic [2:0]       funct3;
  logic             jump;
  logic             rf_we;
  logic [1:0]       wb_sel;
  logic             halt_req;

  assign imem_addr    = pc;
  assign dmem_addr    = alu_result; // lw/sw address from rs1 + imm
  assign dmem_wdata   = rs2_data;
  assign branch_taken = branch & branch_cond;

  rv_pc #(.reset_addr(reset_addr)) pc_i (
    .clk          (clk),
    .rst          (rst),
    .halt_req     (halt_req),
    .branch_taken (branch_taken),
    .jump         (jump),
    .offset       (offset),
    .pc           (pc),
    .pc_plus4     (pc_plus4),
    .halt         (halt)
  );

  rv_decode decode_i (
    .insn     (rv_pkg::insn_t'(imem_data)),
    .halt     (halt),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm),
    .offset   (offset),
    .alu_op   (alu_op),
    .use_imm  (use_imm),
    .branch   (branch),
    .funct3   (funct3),
    .jump     (jump),
    .rf_we    (rf_we),
    .wb_sel   (wb_sel),
    .dmem_we  (dmem_we),
    .halt_req (halt_req)
  );

  rv_regfile #(.num_regs(num_regs)) regfile_i (
    .clk        (clk),
    .rst        (rst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .rd         (rd),
    .we         (rf_we),
    .wb_sel     (wb_sel),
    .alu_result (alu_result),
    .load_data  (dmem_rdata),
    .pc_plus4   (pc_plus4)
  );

  rv_alu alu_i (
    .a           (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .use_imm     (use_imm),
    .alu_op      (alu_op),
    .funct3      (funct3),
    .result      (alu_result),
    .branch_cond (branch_cond)
  );

endmodule

/* verif/rv_core_assert.sv */
`timescale 1ns/100ps

module rv_core_assert #(
  parameter rv_pkg::word_t reset_addr = '0
) (
  input logic          clk,
  input logic          rst,
  input logic          halt,
  input rv_pkg::word_t imem_addr,
  input rv_pkg::word_t imem_data,
  input rv_pkg::word_t dmem_addr,
  input logic          dmem_we
);

  int         fails = 0; // read by the testbench summary
  logic [6:0] opcode;
  logic       control;

  assign opcode  = imem_data[6:0];
  assign control = (opcode == rv_pkg::op_branch) || (opcode == rv_pkg::op_jal) ||
                   (opcode == rv_pkg::op_system);

  // first cycle out of reset
  reset_start: assert property (@(posedge clk) $fell(rst) |-> (imem_addr == reset_addr) && !halt)
    else begin
      $error("pc or halt wrong in the first cycle after reset");
      fails++;
    end

  first_no_store: assert property (@(posedge clk)
    $fell(rst) && (opcode != rv_pkg::op_store) |-> !dmem_we)
    else begin
      $error("store strobe in the first cycle without a store");
      fails++;
    end

  pc_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else begin
      $error("instruction address not word aligned");
      fails++;
    end

  dmem_aligned: assert property (@(posedge clk) disable iff (rst)
    (dmem_we || (opcode == rv_pkg::op_load)) |-> dmem_addr[1:0] == 2'b00)
    else begin
      $error("data address not word aligned");
      fails++;
    end

  we_only_store: assert property (@(posedge clk) disable iff (rst)
    (opcode != rv_pkg::op_store) |-> !dmem_we)
    else begin
      $error("store strobe on a non-store instruction");
      fails++;
    end

  // straight-line code steps by one word
  pc_step: assert property (@(posedge clk) disable iff (rst)
    !halt && !control |=> imem_addr == $past(imem_addr) + 32'd4)
    else begin
      $error("pc did not advance by 4");
      fails++;
    end

  halt_rise: assert property (@(posedge clk) disable iff (rst)
    !halt && (imem_data == {25'd0, rv_pkg::op_system}) |=> halt)
    else begin
      $error("ecall did not raise halt");
      fails++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else begin
      $error("halt dropped without reset");
      fails++;
    end

  halt_pc_hold: assert property (@(posedge clk) disable iff (rst)
    halt |=> imem_addr == $past(imem_addr))
    else begin
      $error("pc moved while halted");
      fails++;
    end

  halt_no_store: assert property (@(posedge clk) disable iff (rst) halt |-> !dmem_we)
    else begin
      $error("store strobe while halted");
      fails++;
    end

endmodule

bind rv_core rv_core_assert #(.reset_addr(reset_addr)) assert_i (
  .clk       (clk),
  .rst       (rst),
  .halt      (halt),
  .imem_addr (imem_addr),
  .imem_data (imem_data),
  .dmem_addr (dmem_addr),
  .dmem_we   (dmem_we)
);

/* verif/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb;

  localparam rv_pkg::word_t reset_addr  = 32'h0000_0200;
  localparam int            num_tests   = 4;
  localparam int            halt_limit  = 128; // cycles per program
  localparam int            watchdog_ns = num_tests * 64 * 10 * 4;

  logic          clk;
  logic          rst;
  logic          halt;
  logic          dmem_we;
  logic          mem_init;
  rv_pkg::word_t imem_addr;
  rv_pkg::word_t imem_data;
  rv_pkg::word_t imem_off;
  rv_pkg::word_t dmem_addr;
  rv_pkg::word_t dmem_wdata;
  rv_pkg::word_t dmem_rdata;

  rv_pkg::word_t imem [64];
  rv_pkg::word_t dmem [64];
  rv_pkg::word_t prog [64];    // program being built
  rv_pkg::word_t exp_mem [64]; // expected data image
  int            pc_w;
  int            slot;
  rv_pkg::word_t opa;
  rv_pkg::word_t opb;
  integer        seed;
  int            tests_passed;
  int            tests_failed;

  rv_core #(.reset_addr(reset_addr), .num_regs(32)) rv_core_i (
    .clk        (clk),
    .rst        (rst),
    .halt       (halt),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // unused words hold opcode 0, which the core steps over
  function automatic rv_pkg::word_t insn_fill(input int idx);
    return rv_pkg::word_t'(idx) << 7;
  endfunction

  function automatic rv_pkg::word_t data_fill(input int idx);
    return 32'hd00d_0000 + rv_pkg::word_t'(idx * 4);
  endfunction

  assign imem_off   = imem_addr - reset_addr;
  assign imem_data  = imem[imem_off[7:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  // memory model with both arrays read combinationally
  initial begin
    for (int i = 0; i < 64; i++) begin
      imem[i] = insn_fill(i);
      dmem[i] = data_fill(i);
    end
    forever begin
      @(posedge clk);
      if (mem_init) begin
        for (int i = 0; i < 64; i++) begin
          imem[i] <= prog[i];
          dmem[i] <= data_fill(i);
        end
      end else if (dmem_we) begin
        dmem[dmem_addr[7:2]] <= dmem_wdata;
      end
    end
  end

  function automatic rv_pkg::word_t rtype(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
      input rv_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
    rv_pkg::insn_t w;
    w.r_fmt = {f7, rs2, rs1, f3, rd, rv_pkg::op_op};
    return w;
  endfunction

  function automatic rv_pkg::word_t itype(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
      input logic [2:0] f3, input rv_pkg::reg_idx_t rd, input logic [6:0] opcode);
    rv_pkg::insn_t w;
    w.i_fmt = {imm, rs1, f3, rd, opcode};
    return w;
  endfunction

  function automatic rv_pkg::word_t stype(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2,
      input rv_pkg::reg_idx_t rs1);
    rv_pkg::insn_t w;
    w.s_fmt = {imm[11:5], rs2, rs1, rv_pkg::f3_word, imm[4:0], rv_pkg::op_store};
    return w;
  endfunction

  function automatic rv_pkg::word_t btype(input logic [2:0] f3, input rv_pkg::reg_idx_t rs1,
      input rv_pkg::reg_idx_t rs2, input logic [12:0] imm);
    rv_pkg::insn_t w;
    w.b_fmt = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
    return w;
  endfunction

  function automatic rv_pkg::word_t utype(input logic [19:0] imm, input rv_pkg::reg_idx_t rd);
    rv_pkg::insn_t w;
    w.u_fmt = {imm, rd, rv_pkg::op_lui};
    return w;
  endfunction

  function automatic rv_pkg::word_t jtype(input logic [20:0] imm, input rv_pkg::reg_idx_t rd);
    rv_pkg::insn_t w;
    w.j_fmt = {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
    return w;
  endfunction

  // rv32i arithmetic as the isa defines it
  function automatic rv_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
      input rv_pkg::word_t a, input rv_pkg::word_t b);
    rv_pkg::word_t r;
    case (f3)
      rv_pkg::f3_add:  r = alt ? a - b : a + b;
      rv_pkg::f3_sll:  r = a << b[4:0];
      rv_pkg::f3_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_pkg::f3_sltu: r = (a < b) ? 32'd1 : 32'd0;
      rv_pkg::f3_xor:  r = a ^ b;
      rv_pkg::f3_srl: begin
        if (alt)
          r = $signed(a) >>> b[4:0];
        else
          r = a >> b[4:0];
      end
      rv_pkg::f3_or:   r = a | b;
      default:         r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input rv_pkg::word_t a,
      input rv_pkg::word_t b);
    case (f3)
      rv_pkg::f3_beq:  return a == b;
      rv_pkg::f3_bne:  return a != b;
      rv_pkg::f3_blt:  return $signed(a) < $signed(b);
      rv_pkg::f3_bge:  return $signed(a) >= $signed(b);
      rv_pkg::f3_bltu: return a < b;
      default:         return a >= b;
    endcase
  endfunction

  task automatic clear_program();
    pc_w = 0;
    slot = 0;
    for (int i = 0; i < 64; i++) begin
      prog[i]    = insn_fill(i);
      exp_mem[i] = data_fill(i); // untouched words must keep their fill
    end
  endtask

  task automatic put(input rv_pkg::word_t w);
    prog[pc_w] = w;
    pc_w++;
  endtask

  task automatic load_imm(input rv_pkg::reg_idx_t rd, input rv_pkg::word_t value);
    rv_pkg::word_t hi;
    hi = value + 32'h800; // addi sign-extends the low part
    put(utype(hi[31:12], rd));
    put(itype(value[11:0], rd, rv_pkg::f3_add, rd, rv_pkg::op_op_imm));
  endtask

  task automatic store_result(input rv_pkg::reg_idx_t rs, input rv_pkg::word_t expected);
    put(stype(12'(slot * 4), rs, 5'd0));
    exp_mem[slot] = expected;
    slot++;
  endtask

  // x1 op (x2 or imm) into x3, then store x3
  task automatic alu_step(input logic use_i, input logic [2:0] f3, input logic alt,
      input logic [11:0] imm);
    rv_pkg::word_t b;
    if (use_i) begin
      b = {{20{imm[11]}}, imm};
      put(itype(imm, 5'd1, f3, 5'd3, rv_pkg::op_op_imm));
    end else begin
      b = opb;
      put(rtype(alt ? rv_pkg::funct7_alt : 7'd0, 5'd2, 5'd1, f3, 5'd3));
    end
    store_result(5'd3, alu_model(f3, alt, opa, b));
  endtask

  // x5 keeps the mark when taken, mark + 1 when it falls through
  task automatic branch_step(input logic [2:0] f3, input rv_pkg::reg_idx_t rsa,
      input rv_pkg::reg_idx_t rsb);
    rv_pkg::word_t mark;
    mark = rv_pkg::word_t'(16 + slot * 2);
    put(itype(mark[11:0], 5'd0, rv_pkg::f3_add, 5'd5, rv_pkg::op_op_imm));
    put(btype(f3, rsa, rsb, 13'd8));
    put(itype(12'd1, 5'd5, rv_pkg::f3_add, 5'd5, rv_pkg::op_op_imm));
    store_result(5'd5, branch_model(f3, (rsa == 5'd1) ? opa : opb,
                                    (rsb == 5'd1) ? opa : opb) ? mark : mark + 32'd1);
  endtask

  task automatic run_program(input string name);
    int cycles;
    int bad;
    put(itype(12'd0, 5'd0, 3'd0, 5'd0, rv_pkg::op_system)); // ecall ends every program
    put(stype(12'd252, 5'd0, 5'd0)); // would clear word 63 if halt let it through
    @(posedge clk);
    rst      <= 1'b1;
    mem_init <= 1'b1;
    @(posedge clk);
    mem_init <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    bad = 0;
    while (halt !== 1'b1 && cycles < halt_limit) begin
      @(negedge clk);
      cycles++;
    end
    assert (halt === 1'b1) else begin
      $display("test %s: core did not halt within %0d cycles", name, halt_limit);
      bad++;
    end
    repeat (2) @(negedge clk); // halted core must stay quiet
    for (int i = 0; i < 64; i++) begin
      assert (dmem[i] === exp_mem[i]) else begin
        $display("ERROR %s: word %0d expected %h actual %h", name, i, exp_mem[i], dmem[i]);
        bad++;
      end
    end
    if (bad == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, bad);
    end
  endtask

  task automatic imm_ops();
    rv_pkg::word_t rnd;
    clear_program();
    opa = $random(seed);
    load_imm(5'd1, opa);
    for (int f = 0; f < 8; f++) begin
      rnd = $random(seed);
      if (f == rv_pkg::f3_sll || f == rv_pkg::f3_srl)
        alu_step(1'b1, 3'(f), 1'b0, {7'd0, rnd[4:0]});
      else
        alu_step(1'b1, 3'(f), 1'b0, rnd[11:0]);
      if (f == rv_pkg::f3_srl)
        alu_step(1'b1, 3'(f), 1'b1, {rv_pkg::funct7_alt, rnd[4:0]}); // srai
    end
    put(itype(12'h5a5, 5'd1, rv_pkg::f3_add, 5'd0, rv_pkg::op_op_imm));
    store_result(5'd0, 32'd0); // x0 ignores the write
    run_program("op_imm");
  endtask

  task automatic reg_ops();
    rv_pkg::word_t rnd;
    clear_program();
    opa = $random(seed) | 32'h8000_0000; // negative for sub and sra
    opb = $random(seed);
    load_imm(5'd1, opa);
    load_imm(5'd2, opb);
    for (int f = 0; f < 8; f++) begin
      alu_step(1'b0, 3'(f), 1'b0, 12'd0);
      if (f == rv_pkg::f3_add || f == rv_pkg::f3_srl)
        alu_step(1'b0, 3'(f), 1'b1, 12'd0);
    end
    rnd = $random(seed);
    put(utype(rnd[19:0], 5'd4));
    store_result(5'd4, {rnd[19:0], 12'd0});
    run_program("op_reg");
  endtask

  task automatic branch_jal();
    logic [2:0]    br_f3 [6];
    rv_pkg::word_t link;
    clear_program();
    br_f3 = '{rv_pkg::f3_beq, rv_pkg::f3_bne, rv_pkg::f3_blt,
              rv_pkg::f3_bge, rv_pkg::f3_bltu, rv_pkg::f3_bgeu};
    opa = $random(seed) | 32'h8000_0000; // below opb signed, above it unsigned
    opb = $random(seed) & 32'h7fff_ffff;
    load_imm(5'd1, opa);
    load_imm(5'd2, opb);
    foreach (br_f3[k]) begin
      if (br_f3[k] == rv_pkg::f3_beq || br_f3[k] == rv_pkg::f3_bne) begin
        branch_step(br_f3[k], 5'd1, 5'd1);
        branch_step(br_f3[k], 5'd1, 5'd2);
      end else begin
        branch_step(br_f3[k], 5'd1, 5'd2);
        branch_step(br_f3[k], 5'd2, 5'd1);
      end
    end
    link = reset_addr + rv_pkg::word_t'(pc_w * 4 + 4);
    put(jtype(21'd8, 5'd6));
    put(itype(12'd1, 5'd0, rv_pkg::f3_add, 5'd7, rv_pkg::op_op_imm)); // skipped by jal
    store_result(5'd6, link);
    store_result(5'd7, 32'd0);
    run_program("branch_jal");
  endtask

  task automatic load_store();
    clear_program();
    opa = $random(seed);
    load_imm(5'd1, opa);
    load_imm(5'd3, 32'd32);
    put(stype(12'd40, 5'd1, 5'd0));
    put(itype(12'd40, 5'd0, rv_pkg::f3_word, 5'd2, rv_pkg::op_load));
    put(stype(12'd12, 5'd1, 5'd3)); // base register plus offset
    put(itype(12'd12, 5'd3, rv_pkg::f3_word, 5'd4, rv_pkg::op_load));
    put(itype(12'd1, 5'd4, rv_pkg::f3_add, 5'd4, rv_pkg::op_op_imm));
    put(itype(12'd200, 5'd0, rv_pkg::f3_word, 5'd5, rv_pkg::op_load)); // fill word
    exp_mem[10] = opa;
    exp_mem[11] = opa;
    slot = 0;
    store_result(5'd2, opa);
    store_result(5'd4, opa + 32'd1);
    store_result(5'd5, data_fill(50));
    run_program("load_store");
  endtask

  initial begin
    #(watchdog_ns * 1ns);
    $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rst          = 1'b1;
    mem_init     = 1'b0;
    seed         = 32'h4421_ccd5;
    tests_passed = 0;
    tests_failed = 0;
    imm_ops();
    reg_ops();
    branch_jal();
    load_store();
    $display("%0d tests, %0d passed, %0d failed, %0d assertion failures", num_tests,
             tests_passed, tests_failed, rv_core_i.assert_i.fails);
    if (tests_failed == 0 && rv_core_i.assert_i.fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* rv_core.f */
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_pc.sv
rtl/rv_core.sv
verif/rv_core_assert.sv
verif/rv_core_tb.sv
